// ==== verilog/gmii_consts.svh ====
`ifndef GMII_CONSTS_SVH
`define GMII_CONSTS_SVH

`define GMII_DATA_W         8
`define GMII_STAT_W         16
`define GMII_APB_DATA_W     32
`define GMII_APB_ADDR_W     8

`define GMII_CAPTURE_STAGES 2       // register stages between pin and core.
`define GMII_PREAMBLE_BYTE  8'h55
`define GMII_SFD_BYTE       8'hD5
`define GMII_PREAMBLE_LEN   7       // preamble bytes ahead of the delimiter.
`define GMII_IFG_CYCLES     12

`define GMII_REG_CTRL       8'h00
`define GMII_REG_RX_GOOD    8'h04
`define GMII_REG_RX_BAD     8'h08
`define GMII_REG_TX_FRAMES  8'h0C
`define GMII_REG_CLEAR      8'h10

`endif

// ==== verilog/gmii_pkg.sv ====
`include "gmii_consts.svh"

package gmii_pkg;

    // one byte lane of the GMII bus as seen on the pins.
    typedef struct packed {
        logic [`GMII_DATA_W-1:0] data;
        logic                    en;    // rx_dv on receive, tx_en on transmit.
        logic                    er;
    } gmii_beat_t;

    typedef logic [`GMII_STAT_W-1:0] stat_count_t;

    typedef logic [`GMII_APB_DATA_W-1:0] apb_word_t;

endpackage

// ==== verilog/ssio_sdr_stage.sv ====
`timescale 1ns/1ps
`include "gmii_consts.svh"

module ssio_sdr_stage #(
    parameter type payload_t = logic [7:0],
    parameter int  STAGES    = `GMII_CAPTURE_STAGES
) (
    input  logic     clk_io,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);

    payload_t stage_q [STAGES];   // the first entry is the one meant for the I/O flop.

    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q = stage_q[STAGES-1];

endmodule

// ==== verilog/gmii_rx_monitor.sv ====
`timescale 1ns/1ps
`include "gmii_consts.svh"

module gmii_rx_monitor (
    input  logic                    clk_io,
    input  logic                    rst_n,
    input  logic                    rx_enable,
    input  gmii_pkg::gmii_beat_t    beat,
    output logic [`GMII_DATA_W-1:0] rx_data,
    output logic                    rx_valid,
    output logic                    rx_last,
    output logic                    rx_err,
    output logic                    frame_good,
    output logic                    frame_bad
);
    import gmii_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_DROP
    } state_t;

    localparam logic [3:0] PRE_LEN = 4'(`GMII_PREAMBLE_LEN);

    state_t     state;
    logic [3:0] pre_cnt;
    logic       prev_en;
    gmii_beat_t hold_q;     // en flags a held byte, er gathers errors of the frame so far.
    logic       good_q;
    logic       bad_q;
    logic       is_pre;
    logic       is_sfd;

    assign is_pre = beat.en && !beat.er && (beat.data == `GMII_PREAMBLE_BYTE);
    assign is_sfd = beat.en && !beat.er && (beat.data == `GMII_SFD_BYTE);

    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            pre_cnt <= '0;
            prev_en <= 1'b0;
            hold_q  <= '0;
            good_q  <= 1'b0;
            bad_q   <= 1'b0;
        end else begin
            prev_en <= beat.en;
            good_q  <= 1'b0;
            bad_q   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (beat.en && !prev_en) begin
                        if (!rx_enable) begin
                            state <= ST_DROP;   // frames starting while disabled are not counted.
                        end else if (is_sfd) begin
                            state  <= ST_PAYLOAD;
                            hold_q <= '0;
                        end else if (is_pre) begin
                            state   <= ST_PREAMBLE;
                            pre_cnt <= 4'd1;
                        end else begin
                            state <= ST_DROP;
                            bad_q <= 1'b1;
                        end
                    end
                end
                ST_PREAMBLE: begin
                    if (is_sfd) begin
                        state  <= ST_PAYLOAD;
                        hold_q <= '0;
                    end else if (is_pre && pre_cnt < PRE_LEN) begin
                        pre_cnt <= pre_cnt + 4'd1;
                    end else begin
                        bad_q <= 1'b1;
                        state <= beat.en ? ST_DROP : ST_IDLE;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat.en) begin
                        hold_q <= '{data: beat.data, en: 1'b1, er: hold_q.er | beat.er};
                    end else begin
                        state  <= ST_IDLE;
                        hold_q <= '0;
                        good_q <= !hold_q.en;   // an empty frame has no last byte to report on.
                    end
                end
                ST_DROP: begin
                    if (!beat.en) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // the held byte is the last one once the line goes quiet behind it.
    assign rx_data    = hold_q.data;
    assign rx_valid   = hold_q.en;
    assign rx_last    = hold_q.en && !beat.en;
    assign rx_err     = rx_last && hold_q.er;
    assign frame_good = (rx_last && !hold_q.er) || good_q;
    assign frame_bad  = (rx_last && hold_q.er) || bad_q;

endmodule

// ==== verilog/gmii_tx_framer.sv ====
`timescale 1ns/1ps
`include "gmii_consts.svh"

module gmii_tx_framer (
    input  logic                    clk_io,
    input  logic                    rst_n,
    input  logic                    tx_enable,
    input  logic [`GMII_DATA_W-1:0] tx_data,
    input  logic                    tx_valid,
    input  logic                    tx_last,
    output logic                    tx_ready,
    output gmii_pkg::gmii_beat_t    beat,
    output logic                    frame_sent
);
    import gmii_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_GAP
    } state_t;

    localparam logic [3:0] PRE_LEN  = 4'(`GMII_PREAMBLE_LEN);
    localparam logic [3:0] GAP_LAST = 4'(`GMII_IFG_CYCLES - 1);

    state_t                  state;
    logic [3:0]              cnt;
    logic [`GMII_DATA_W-1:0] first_data;
    logic                    first_last;
    gmii_beat_t              beat_q;
    logic                    sent_q;
    logic                    accept;

    // a started frame is always finished, even if tx_enable drops.
    assign tx_ready   = (state == ST_IDLE && tx_enable) || (state == ST_PAYLOAD);
    assign accept     = tx_valid && tx_ready;
    assign beat       = beat_q;
    assign frame_sent = sent_q;

    always_ff @(posedge clk_io) begin
        if (state == ST_IDLE && accept) begin
            first_data <= tx_data;
            first_last <= tx_last;
        end
    end

    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            cnt    <= '0;
            beat_q <= '0;
            sent_q <= 1'b0;
        end else begin
            sent_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    beat_q <= '0;
                    if (accept) begin
                        beat_q <= '{data: `GMII_PREAMBLE_BYTE, en: 1'b1, er: 1'b0};
                        cnt    <= 4'd1;
                        state  <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (cnt < PRE_LEN) begin
                        beat_q <= '{data: `GMII_PREAMBLE_BYTE, en: 1'b1, er: 1'b0};
                        cnt    <= cnt + 4'd1;
                    end else if (cnt == PRE_LEN) begin
                        beat_q <= '{data: `GMII_SFD_BYTE, en: 1'b1, er: 1'b0};
                        cnt    <= cnt + 4'd1;
                    end else begin
                        beat_q <= '{data: first_data, en: 1'b1, er: 1'b0};
                        cnt    <= '0;
                        if (first_last) begin
                            sent_q <= 1'b1;
                            state  <= ST_GAP;
                        end else begin
                            state <= ST_PAYLOAD;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (accept) begin
                        beat_q <= '{data: tx_data, en: 1'b1, er: 1'b0};
                        if (tx_last) begin
                            sent_q <= 1'b1;
                            state  <= ST_GAP;
                        end
                    end else begin
                        beat_q <= '0;   // user underrun breaks the frame on the line.
                    end
                end
                ST_GAP: begin
                    beat_q <= '0;
                    if (cnt == GAP_LAST) begin
                        cnt   <= '0;
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== verilog/gmii_apb_regs.sv ====
`timescale 1ns/1ps
`include "gmii_consts.svh"

module gmii_apb_regs (
    input  logic                        clk_io,
    input  logic                        rst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`GMII_APB_ADDR_W-1:0] paddr,
    input  gmii_pkg::apb_word_t         pwdata,
    input  logic                        frame_good,
    input  logic                        frame_bad,
    input  logic                        frame_sent,
    output gmii_pkg::apb_word_t         prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        rx_enable,
    output logic                        tx_enable
);
    import gmii_pkg::*;

    logic [1:0]  ctrl_q;
    stat_count_t rx_good_q;
    stat_count_t rx_bad_q;
    stat_count_t tx_frames_q;
    logic        access;
    logic        addr_hit;
    logic        wr_ctrl;
    logic        wr_clear;

    function automatic stat_count_t sat_inc(input stat_count_t value, input logic hit);
        if (hit && value != '1) begin
            return value + 1'b1;
        end
        return value;   // counters hold at full scale.
    endfunction

    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            `GMII_REG_CTRL:      prdata = apb_word_t'(ctrl_q);
            `GMII_REG_RX_GOOD:   prdata = apb_word_t'(rx_good_q);
            `GMII_REG_RX_BAD:    prdata = apb_word_t'(rx_bad_q);
            `GMII_REG_TX_FRAMES: prdata = apb_word_t'(tx_frames_q);
            `GMII_REG_CLEAR:     prdata = '0;   // write-only strobe.
            default:             addr_hit = 1'b0;
        endcase
    end

    assign access   = psel && penable;
    assign pready   = 1'b1;
    assign pslverr  = access && !addr_hit;
    assign wr_ctrl  = access && pwrite && (paddr == `GMII_REG_CTRL);
    assign wr_clear = access && pwrite && (paddr == `GMII_REG_CLEAR) && pwdata[0];

    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            ctrl_q      <= '0;
            rx_good_q   <= '0;
            rx_bad_q    <= '0;
            tx_frames_q <= '0;
        end else begin
            if (wr_ctrl) begin
                ctrl_q <= pwdata[1:0];
            end
            if (wr_clear) begin
                rx_good_q   <= '0;
                rx_bad_q    <= '0;
                tx_frames_q <= '0;
            end else begin
                rx_good_q   <= sat_inc(rx_good_q, frame_good);
                rx_bad_q    <= sat_inc(rx_bad_q, frame_bad);
                tx_frames_q <= sat_inc(tx_frames_q, frame_sent);
            end
        end
    end

    assign rx_enable = ctrl_q[0];
    assign tx_enable = ctrl_q[1];

endmodule

// ==== verilog/gmii_phy_top.sv ====
`timescale 1ns/1ps
`include "gmii_consts.svh"

module gmii_phy_top (
    input  logic                        clk_io,
    input  logic                        rst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`GMII_APB_ADDR_W-1:0] paddr,
    input  gmii_pkg::apb_word_t         pwdata,
    output gmii_pkg::apb_word_t         prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic [`GMII_DATA_W-1:0]     gmii_rxd,
    input  logic                        gmii_rx_dv,
    input  logic                        gmii_rx_er,
    output logic [`GMII_DATA_W-1:0]     gmii_txd,
    output logic                        gmii_tx_en,
    output logic                        gmii_tx_er,
    output logic [`GMII_DATA_W-1:0]     rx_data,
    output logic                        rx_valid,
    output logic                        rx_last,
    output logic                        rx_err,
    input  logic [`GMII_DATA_W-1:0]     tx_data,
    input  logic                        tx_valid,
    input  logic                        tx_last,
    output logic                        tx_ready
);
    import gmii_pkg::*;

    gmii_beat_t rx_pin_beat;
    gmii_beat_t rx_beat;
    gmii_beat_t tx_beat;
    gmii_beat_t tx_pin_beat;
    logic       rx_enable;
    logic       tx_enable;
    logic       frame_good;
    logic       frame_bad;
    logic       frame_sent;

    assign rx_pin_beat = '{data: gmii_rxd, en: gmii_rx_dv, er: gmii_rx_er};
    assign gmii_txd    = tx_pin_beat.data;
    assign gmii_tx_en  = tx_pin_beat.en;
    assign gmii_tx_er  = tx_pin_beat.er;

    ssio_sdr_stage #(.payload_t(gmii_beat_t), .STAGES(`GMII_CAPTURE_STAGES)) i_rx_stage (
        .clk_io (clk_io),
        .rst_n  (rst_n),
        .d      (rx_pin_beat),
        .q      (rx_beat)
    );

    gmii_rx_monitor i_rx_monitor (
        .clk_io     (clk_io),
        .rst_n      (rst_n),
        .rx_enable  (rx_enable),
        .beat       (rx_beat),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_last    (rx_last),
        .rx_err     (rx_err),
        .frame_good (frame_good),
        .frame_bad  (frame_bad)
    );

    gmii_tx_framer i_tx_framer (
        .clk_io     (clk_io),
        .rst_n      (rst_n),
        .tx_enable  (tx_enable),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_last    (tx_last),
        .tx_ready   (tx_ready),
        .beat       (tx_beat),
        .frame_sent (frame_sent)
    );

    ssio_sdr_stage #(.payload_t(gmii_beat_t), .STAGES(`GMII_CAPTURE_STAGES)) i_tx_stage (
        .clk_io (clk_io),
        .rst_n  (rst_n),
        .d      (tx_beat),
        .q      (tx_pin_beat)
    );

    gmii_apb_regs i_apb_regs (
        .clk_io     (clk_io),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .frame_good (frame_good),
        .frame_bad  (frame_bad),
        .frame_sent (frame_sent),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .rx_enable  (rx_enable),
        .tx_enable  (tx_enable)
    );

endmodule

// ==== testbench/gmii_asserts.sv ====
`timescale 1ns/1ps
`include "gmii_consts.svh"

module gmii_asserts (
    input logic clk_io,
    input logic rst_n,
    input logic psel,
    input logic pready,
    input logic tx_valid,
    input logic tx_ready,
    input logic tx_last,
    input logic gmii_tx_en,
    input logic rx_valid,
    input logic rx_last
);

    logic mid_frame;   // set between the first accepted byte and the accepted last byte.

    always_ff @(posedge clk_io) begin
        if (!rst_n) begin
            mid_frame <= 1'b0;
        end else if (tx_valid && tx_ready) begin
            mid_frame <= !tx_last;
        end
    end

    a_tx_valid_held: assert property (@(posedge clk_io) disable iff (!rst_n)
        mid_frame |-> tx_valid) else $error("tx_valid dropped inside a frame.");

    a_pready_high: assert property (@(posedge clk_io) disable iff (!rst_n)
        psel |-> pready) else $error("pready low during an APB access.");

    // preamble, delimiter and at least one byte go out without a break.
    a_tx_en_window: assert property (@(posedge clk_io) disable iff (!rst_n)
        $rose(gmii_tx_en) |-> gmii_tx_en [*(`GMII_PREAMBLE_LEN + 2)])
        else $error("gmii_tx_en window broken.");

    a_tx_en_gap: assert property (@(posedge clk_io) disable iff (!rst_n)
        $fell(gmii_tx_en) |-> !gmii_tx_en [*(`GMII_IFG_CYCLES - 1)])
        else $error("gmii_tx_en came back inside the gap.");

    a_rx_last_valid: assert property (@(posedge clk_io) disable iff (!rst_n)
        rx_last |-> rx_valid) else $error("rx_last without rx_valid.");

endmodule

bind gmii_phy_top gmii_asserts i_asserts (
    .clk_io     (clk_io),
    .rst_n      (rst_n),
    .psel       (psel),
    .pready     (pready),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .tx_last    (tx_last),
    .gmii_tx_en (gmii_tx_en),
    .rx_valid   (rx_valid),
    .rx_last    (rx_last)
);

// ==== testbench/gmii_tb.sv ====
`timescale 1ns/1ps
`include "gmii_consts.svh"

module gmii_tb;
    import gmii_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int MAX_PAYLOAD  = 16;
    localparam int FRAME_CYCLES = `GMII_PREAMBLE_LEN + 1 + MAX_PAYLOAD + `GMII_IFG_CYCLES + 12;
    localparam int FRAME_COUNT  = 9;
    localparam int APB_CYCLES   = 40 * 4;
    localparam int WATCHDOG_CYCLES = 2 * (FRAME_COUNT * FRAME_CYCLES + APB_CYCLES) + 100;
    localparam int PRE_OK      = 0;
    localparam int PRE_CORRUPT = 1;
    localparam int PRE_SHORT   = 2;

    logic                        clk_io = 1'b0;
    logic                        rst_n;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`GMII_APB_ADDR_W-1:0] paddr;
    apb_word_t                   pwdata;
    apb_word_t                   prdata;
    logic                        pready;
    logic                        pslverr;
    logic [7:0]                  rxd_drv;
    logic                        rx_dv_drv;
    logic                        rx_er_drv;
    logic                        loopback;
    logic [7:0]                  gmii_rxd;
    logic                        gmii_rx_dv;
    logic                        gmii_rx_er;
    logic [7:0]                  gmii_txd;
    logic                        gmii_tx_en;
    logic                        gmii_tx_er;
    logic [7:0]                  rx_data;
    logic                        rx_valid;
    logic                        rx_last;
    logic                        rx_err;
    logic [7:0]                  tx_data;
    logic                        tx_valid;
    logic                        tx_last;
    logic                        tx_ready;

    gmii_beat_t  rx_q[$];
    gmii_beat_t  exp_rx_q[$];
    gmii_beat_t  tx_pin_q[$];
    logic [7:0]  payload_q[$];
    logic [15:0] lfsr_q = 16'd98;
    logic        tx_en_prev = 1'b0;
    int          tx_en_windows;
    int          errors;
    int          start_errors;
    int          tests_run;
    int          tests_failed;
    string       cur_test;
    stat_count_t exp_good;
    stat_count_t exp_bad;
    stat_count_t exp_sent;

    assign gmii_rxd   = loopback ? gmii_txd : rxd_drv;
    assign gmii_rx_dv = loopback ? gmii_tx_en : rx_dv_drv;
    assign gmii_rx_er = loopback ? gmii_tx_er : rx_er_drv;

    gmii_phy_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk_io = ~clk_io;

    always @(posedge clk_io) begin
        if (rx_valid) begin
            rx_q.push_back('{data: rx_data, en: rx_last, er: rx_err});  // en marks the last byte.
        end
        if (gmii_tx_en) begin
            tx_pin_q.push_back('{data: gmii_txd, en: gmii_tx_en, er: gmii_tx_er});
        end
        if (gmii_tx_en && !tx_en_prev) begin
            tx_en_windows++;
        end
        tx_en_prev = gmii_tx_en;
    end

    // fibonacci lfsr on x^16 + x^14 + x^13 + x^11 + 1 that steps once per bit taken.
    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[6:0], fb};
        end
        return v;
    endfunction

    task automatic check_beat(input string what, input gmii_beat_t exp, input gmii_beat_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input stat_count_t exp, input stat_count_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input apb_word_t exp, input apb_word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("ERROR %s: %s", cur_test, msg);
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        start_errors = errors;
        rx_q.delete();
        exp_rx_q.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - start_errors);
        end
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr, input apb_word_t wdata,
                              output apb_word_t rdata, output logic err);
        @(negedge clk_io);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_io);
        penable = 1'b1;
        @(posedge clk_io);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk_io);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input apb_word_t data);
        apb_word_t rd;
        logic      err;
        apb_access(1'b1, addr, data, rd, err);
        if (err) note_failure($sformatf("write to offset %h answered with pslverr", addr));
    endtask

    task automatic apb_read(input logic [7:0] addr, output apb_word_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        if (err) note_failure($sformatf("read of offset %h answered with pslverr", addr));
    endtask

    task automatic check_counters();
        apb_word_t w;
        apb_read(`GMII_REG_RX_GOOD, w);
        check_count("RX_GOOD", exp_good, stat_count_t'(w));
        apb_read(`GMII_REG_RX_BAD, w);
        check_count("RX_BAD", exp_bad, stat_count_t'(w));
        apb_read(`GMII_REG_TX_FRAMES, w);
        check_count("TX_FRAMES", exp_sent, stat_count_t'(w));
    endtask

    task automatic fill_payload(input int len);
        payload_q.delete();
        repeat (len) payload_q.push_back(lfsr_bits(8));
    endtask

    task automatic expect_frame(input logic err);
        foreach (payload_q[i]) begin
            exp_rx_q.push_back('{data: payload_q[i], en: (i == payload_q.size() - 1),
                                 er: err && (i == payload_q.size() - 1)});
        end
    endtask

    task automatic compare_rx();
        int n;
        if (rx_q.size() != exp_rx_q.size()) begin
            note_failure($sformatf("received %0d bytes where %0d were expected",
                                   rx_q.size(), exp_rx_q.size()));
        end
        n = (rx_q.size() < exp_rx_q.size()) ? rx_q.size() : exp_rx_q.size();
        for (int i = 0; i < n; i++) begin
            check_beat($sformatf("rx byte %0d", i), exp_rx_q[i], rx_q[i]);
        end
    endtask

    task automatic send_rx_frame(input int err_pos, input int pre_mode);
        int n_pre;
        n_pre = (pre_mode == PRE_SHORT) ? 4 : `GMII_PREAMBLE_LEN;
        @(negedge clk_io);
        rx_dv_drv = 1'b1;
        rx_er_drv = 1'b0;
        for (int i = 0; i < n_pre; i++) begin
            rxd_drv = (pre_mode == PRE_CORRUPT && i == 3) ? 8'h5A : `GMII_PREAMBLE_BYTE;
            @(negedge clk_io);
        end
        if (pre_mode != PRE_SHORT) begin
            rxd_drv = `GMII_SFD_BYTE;
            @(negedge clk_io);
            foreach (payload_q[i]) begin
                rxd_drv   = payload_q[i];
                rx_er_drv = (i == err_pos);
                @(negedge clk_io);
            end
        end
        rx_dv_drv = 1'b0;
        rx_er_drv = 1'b0;
        rxd_drv   = '0;
        repeat (6) @(negedge clk_io);   // lets the frame drain through the stage and monitor.
    endtask

    task automatic send_tx_frame();
        foreach (payload_q[i]) begin
            @(negedge clk_io);
            tx_valid = 1'b1;
            tx_data  = payload_q[i];
            tx_last  = (i == payload_q.size() - 1);
            @(posedge clk_io);
            while (!tx_ready) @(posedge clk_io);
        end
        @(negedge clk_io);
        tx_valid = 1'b0;
        tx_last  = 1'b0;
    endtask

    task automatic wait_tx_ready(output int low_cycles);
        low_cycles = 0;
        @(posedge clk_io);
        while (!tx_ready) begin
            low_cycles++;
            @(posedge clk_io);
        end
    endtask

    task automatic test_regs_reset();
        apb_word_t w;
        logic      err;
        begin_test("regs_reset");
        apb_read(`GMII_REG_CTRL, w);
        check_word("CTRL after reset", '0, w);
        check_counters();
        apb_read(`GMII_REG_CLEAR, w);
        check_word("CLEAR read", '0, w);
        apb_write(`GMII_REG_CTRL, 32'h3);
        apb_read(`GMII_REG_CTRL, w);
        check_word("CTRL readback", 32'h3, w);
        apb_write(`GMII_REG_CTRL, 32'h0);
        apb_access(1'b0, 8'h14, '0, w, err);
        if (!err) note_failure("offset 14 was accepted without pslverr");
        end_test();
    endtask

    task automatic test_tx_framing();
        int gap;
        begin_test("tx_framing");
        apb_write(`GMII_REG_CTRL, 32'h2);
        tx_pin_q.delete();
        tx_en_windows = 0;
        fill_payload(2 + int'(lfsr_bits(3)));  // the last byte is accepted after the preamble.
        send_tx_frame();
        wait_tx_ready(gap);
        exp_sent++;
        if (gap < `GMII_IFG_CYCLES) begin
            note_failure($sformatf("tx_ready came back after %0d cycles", gap));
        end
        if (tx_en_windows != 1) note_failure("gmii_tx_en was not one contiguous window");
        if (tx_pin_q.size() != payload_q.size() + 8) begin
            note_failure($sformatf("%0d beats under gmii_tx_en", tx_pin_q.size()));
        end else begin
            for (int i = 0; i < tx_pin_q.size(); i++) begin
                check_beat($sformatf("tx pin beat %0d", i),
                           '{data: (i < 7) ? 8'h55 : (i == 7) ? 8'hD5 : payload_q[i-8],
                             en: 1'b1, er: 1'b0}, tx_pin_q[i]);
            end
        end
        check_counters();
        end_test();
    endtask

    task automatic test_loopback();
        int gap;
        begin_test("loopback");
        apb_write(`GMII_REG_CTRL, 32'h3);
        @(negedge clk_io);
        loopback = 1'b1;
        repeat (4) begin
            fill_payload(1 + int'(lfsr_bits(4)));
            expect_frame(1'b0);
            send_tx_frame();
            wait_tx_ready(gap);
            exp_good++;
            exp_sent++;
        end
        repeat (4) @(negedge clk_io);
        loopback = 1'b0;
        compare_rx();
        check_counters();
        end_test();
    endtask

    task automatic test_bad_frames();
        begin_test("bad_frames");
        apb_write(`GMII_REG_CTRL, 32'h1);
        fill_payload(3 + int'(lfsr_bits(3)));
        expect_frame(1'b1);
        send_rx_frame(1, PRE_OK);
        fill_payload(4);
        send_rx_frame(-1, PRE_CORRUPT);
        send_rx_frame(-1, PRE_SHORT);
        exp_bad = exp_bad + 3;
        compare_rx();
        check_counters();
        end_test();
    endtask

    task automatic test_disable_clear();
        apb_word_t w;
        begin_test("disable_clear");
        apb_write(`GMII_REG_CTRL, 32'h0);
        fill_payload(5);
        send_rx_frame(-1, PRE_OK);
        compare_rx();
        check_counters();
        apb_write(`GMII_REG_CLEAR, 32'h1);
        exp_good = '0;
        exp_bad  = '0;
        exp_sent = '0;
        check_counters();
        apb_read(`GMII_REG_CLEAR, w);
        check_word("CLEAR read", '0, w);
        end_test();
    endtask

    initial begin
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rxd_drv   = '0;
        rx_dv_drv = 1'b0;
        rx_er_drv = 1'b0;
        loopback  = 1'b0;
        tx_data   = '0;
        tx_valid  = 1'b0;
        tx_last   = 1'b0;
        errors    = 0;
        exp_good  = '0;
        exp_bad   = '0;
        exp_sent  = '0;
        repeat (3) @(posedge clk_io);
        @(negedge clk_io);
        rst_n = 1'b1;
        test_regs_reset();
        test_tx_framing();
        test_loopback();
        test_bad_frames();
        test_disable_clear();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, cur_test);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/gmii_pkg.sv
verilog/ssio_sdr_stage.sv
verilog/gmii_rx_monitor.sv
verilog/gmii_tx_framer.sv
verilog/gmii_apb_regs.sv
verilog/gmii_phy_top.sv
testbench/gmii_asserts.sv
testbench/gmii_tb.sv

// ==== Bender.yml ====
package:
  name: gmii_phy

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/gmii_pkg.sv
      - verilog/ssio_sdr_stage.sv
      - verilog/gmii_rx_monitor.sv
      - verilog/gmii_tx_framer.sv
      - verilog/gmii_apb_regs.sv
      - verilog/gmii_phy_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/gmii_asserts.sv
      - testbench/gmii_tb.sv
